// File: logic/spi_clk_gen.sv
// sclk period is 2 x (divider + 1) system clocks; sclk idles low and stops after the last bit
`timescale 1ns/1ps
`default_nettype none

module spi_clk_gen #(
  parameter int DIVIDER_LEN = 16
) (
  input  logic                   wb_clk_i,
  input  logic                   rst,
  input  logic [DIVIDER_LEN-1:0] divider_i,
  input  logic                   tip_i,
  input  logic                   go_i,
  input  logic                   last_i,
  output logic                   sclk_o,
  output logic                   pos_edge_o,
  output logic                   neg_edge_o
);

  logic [DIVIDER_LEN-1:0] cnt_q; // half period count
  logic                   cnt_zero;
  logic                   cnt_one;
  logic                   div_zero;

  assign cnt_zero = (cnt_q == '0);
  assign cnt_one  = (cnt_q == DIVIDER_LEN'(1));
  assign div_zero = (divider_i == '0);

  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      cnt_q <= '1;
    else if (!tip_i || cnt_zero)
      cnt_q <= divider_i;
    else
      cnt_q <= cnt_q - DIVIDER_LEN'(1);
  end

  // no new rising edge once the last bit is reached
  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      sclk_o <= 1'b0;
    else if (tip_i && cnt_zero && (!last_i || sclk_o))
      sclk_o <= ~sclk_o;
  end

  // edge pulses lead the sclk transitions by one clock
  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
    begin
      pos_edge_o <= 1'b0;
      neg_edge_o <= 1'b0;
    end
    else
    begin
      pos_edge_o <= (tip_i && !sclk_o && cnt_one) || (div_zero && sclk_o) ||
                    (div_zero && go_i && !tip_i);
      neg_edge_o <= (tip_i && sclk_o && cnt_one) || (div_zero && !sclk_o && tip_i);
    end
  end

endmodule

`default_nettype wire

// File: logic/spi_master_top.sv
// DIVIDER_LEN and SS_NB each 1 to 32; no error output, interrupt is a level cleared by the next ack
`timescale 1ns/1ps
`default_nettype none

module spi_master_top #(
  parameter int DIVIDER_LEN = 16,
  parameter int SS_NB       = 8
) (
  input  logic               wb_clk_i,
  input  logic               rst,
  input  logic [4:0]         wb_adr_i,
  input  spi_pkg::spi_word_t wb_dat_i,
  input  logic [3:0]         wb_sel_i,
  input  logic               wb_we_i,
  input  logic               wb_stb_i,
  input  logic               wb_cyc_i,
  input  logic               miso_pad_i,
  output spi_pkg::spi_word_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_int_o,
  output logic [SS_NB-1:0]   ss_pad_o,
  output logic               sclk_pad_o,
  output logic               mosi_pad_o
);
  import spi_pkg::*;

  spi_ctrl_u              ctrl;
  logic [DIVIDER_LEN-1:0] divider;
  spi_word_t              rx_data;
  spi_bit_cnt_t           bit_cnt;
  logic                   tx_load;
  logic                   tip;
  logic                   done;
  logic                   last;
  logic                   pos_edge;
  logic                   neg_edge;

  spi_wb_regs #(
    .DIVIDER_LEN (DIVIDER_LEN),
    .SS_NB       (SS_NB)
  ) u_regs (
    .wb_clk_i  (wb_clk_i),
    .rst       (rst),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_we_i   (wb_we_i),
    .wb_stb_i  (wb_stb_i),
    .wb_cyc_i  (wb_cyc_i),
    .rx_data_i (rx_data),
    .tip_i     (tip),
    .done_i    (done),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .wb_int_o  (wb_int_o),
    .ctrl_o    (ctrl),
    .divider_o (divider),
    .ss_pad_o  (ss_pad_o),
    .tx_load_o (tx_load)
  );

  spi_clk_gen #(
    .DIVIDER_LEN (DIVIDER_LEN)
  ) u_clk_gen (
    .wb_clk_i   (wb_clk_i),
    .rst        (rst),
    .divider_i  (divider),
    .tip_i      (tip),
    .go_i       (ctrl.f.go),
    .last_i     (last),
    .sclk_o     (sclk_pad_o),
    .pos_edge_o (pos_edge),
    .neg_edge_o (neg_edge)
  );

  spi_xfer_fsm u_fsm (
    .wb_clk_i   (wb_clk_i),
    .rst        (rst),
    .go_i       (ctrl.f.go),
    .char_len_i (ctrl.f.char_len),
    .pos_edge_i (pos_edge),
    .tip_o      (tip),
    .done_o     (done),
    .last_o     (last),
    .bit_cnt_o  (bit_cnt)
  );

  spi_shift_reg u_shift (
    .wb_clk_i     (wb_clk_i),
    .rst          (rst),
    .tx_load_i    (tx_load),
    .byte_sel_i   (wb_sel_i),
    .tx_data_i    (wb_dat_i),
    .tip_i        (tip),
    .pos_edge_i   (pos_edge),
    .neg_edge_i   (neg_edge),
    .last_i       (last),
    .bit_cnt_i    (bit_cnt),
    .char_len_i   (ctrl.f.char_len),
    .lsb_i        (ctrl.f.lsb),
    .tx_negedge_i (ctrl.f.tx_negedge),
    .rx_negedge_i (ctrl.f.rx_negedge),
    .sclk_i       (sclk_pad_o),
    .miso_i       (miso_pad_i),
    .rx_data_o    (rx_data),
    .mosi_o       (mosi_pad_o)
  );

endmodule

`default_nettype wire

// File: logic/spi_pkg.sv
// 32-bit Wishbone data bus only; characters are 1 to 32 bits and a length of 0 means 32
`default_nettype none

package spi_pkg;

  typedef logic [31:0] spi_word_t;

  localparam int SPI_MAX_CHAR      = 32;
  localparam int SPI_CHAR_LEN_BITS = 5;
  localparam int SPI_CTRL_BITS     = 14;

  // remaining bits of the character, 32 needs the top bit
  typedef logic [SPI_CHAR_LEN_BITS:0] spi_bit_cnt_t;

  // control and status register, written raw by the bus, read as fields by the datapath
  typedef union packed {
    logic [SPI_CTRL_BITS-1:0] raw;
    struct packed {
      logic                         ass;        // automatic slave select
      logic                         ie;         // end-of-transfer interrupt enable
      logic                         lsb;        // lsb first on the line
      logic                         tx_negedge; // mosi driven on falling sclk
      logic                         rx_negedge; // miso sampled on falling sclk
      logic                         go;         // start, cleared by hardware at the end
      logic [2:0]                   rsvd;
      logic [SPI_CHAR_LEN_BITS-1:0] char_len;
    } f;
  } spi_ctrl_u;

  // register offsets on wb_adr_i[4:2]
  localparam logic [2:0] SPI_ADR_DATA    = 3'd0;
  localparam logic [2:0] SPI_ADR_CTRL    = 3'd4;
  localparam logic [2:0] SPI_ADR_DIVIDER = 3'd5;
  localparam logic [2:0] SPI_ADR_SS      = 3'd6;

  // byte lane merge of a bus write into an existing word
  function automatic spi_word_t byte_merge(spi_word_t old_w, spi_word_t new_w, logic [3:0] sel);
    spi_word_t res;
    res = old_w;
    for (int i = 0; i < 4; i++)
    begin
      if (sel[i])
        res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: logic/spi_shift_reg.sv
// one 32-bit word for transmit and receive; loads while busy are dropped, bits beyond char_len kept
`timescale 1ns/1ps
`default_nettype none

module spi_shift_reg (
  input  logic                                  wb_clk_i,
  input  logic                                  rst,
  input  logic                                  tx_load_i,
  input  logic [3:0]                            byte_sel_i,
  input  spi_pkg::spi_word_t                    tx_data_i,
  input  logic                                  tip_i,
  input  logic                                  pos_edge_i,
  input  logic                                  neg_edge_i,
  input  logic                                  last_i,
  input  spi_pkg::spi_bit_cnt_t                 bit_cnt_i,
  input  logic [spi_pkg::SPI_CHAR_LEN_BITS-1:0] char_len_i,
  input  logic                                  lsb_i,
  input  logic                                  tx_negedge_i,
  input  logic                                  rx_negedge_i,
  input  logic                                  sclk_i,
  input  logic                                  miso_i,
  output spi_pkg::spi_word_t                    rx_data_o,
  output logic                                  mosi_o
);
  import spi_pkg::*;

  spi_word_t    data_q;
  spi_bit_cnt_t len_full; // char_len with 0 read as 32
  spi_bit_cnt_t rx_ref;
  spi_bit_cnt_t tx_pos;
  spi_bit_cnt_t rx_pos;
  logic         tx_clk;
  logic         rx_clk;

  assign len_full = {~(|char_len_i), char_len_i};

  // a falling edge sample lags the counter by one bit
  assign rx_ref = rx_negedge_i ? bit_cnt_i + spi_bit_cnt_t'(1) : bit_cnt_i;

  assign tx_pos = lsb_i ? len_full - bit_cnt_i : bit_cnt_i - spi_bit_cnt_t'(1);
  assign rx_pos = lsb_i ? len_full - rx_ref : rx_ref - spi_bit_cnt_t'(1);

  assign tx_clk = tip_i & (tx_negedge_i ? neg_edge_i : pos_edge_i) & ~last_i;
  assign rx_clk = tip_i & (rx_negedge_i ? neg_edge_i : pos_edge_i) & (~last_i | sclk_i);

  // first bit is presented while idle so it is ready before the first sclk edge
  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      mosi_o <= 1'b0;
    else if (tx_clk || !tip_i)
      mosi_o <= data_q[tx_pos[SPI_CHAR_LEN_BITS-1:0]];
  end

  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      data_q <= '0;
    else if (tx_load_i && !tip_i)
      data_q <= byte_merge(data_q, tx_data_i, byte_sel_i);
    else if (rx_clk)
      data_q[rx_pos[SPI_CHAR_LEN_BITS-1:0]] <= miso_i; // sent bit slot reused
  end

  assign rx_data_o = data_q;

endmodule

`default_nettype wire

// File: logic/spi_wb_regs.sv
// single-cycle ack, every other cycle on a held strobe; register writes are dropped while busy
`timescale 1ns/1ps
`default_nettype none

module spi_wb_regs #(
  parameter int DIVIDER_LEN = 16,
  parameter int SS_NB       = 8
) (
  input  logic                   wb_clk_i,
  input  logic                   rst,
  input  logic [4:0]             wb_adr_i,
  input  spi_pkg::spi_word_t     wb_dat_i,
  input  logic [3:0]             wb_sel_i,
  input  logic                   wb_we_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_cyc_i,
  input  spi_pkg::spi_word_t     rx_data_i,
  input  logic                   tip_i,
  input  logic                   done_i,
  output spi_pkg::spi_word_t     wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   wb_int_o,
  output spi_pkg::spi_ctrl_u     ctrl_o,
  output logic [DIVIDER_LEN-1:0] divider_o,
  output logic [SS_NB-1:0]       ss_pad_o,
  output logic                   tx_load_o
);
  import spi_pkg::*;

  logic                   bus_valid;
  logic                   reg_wr;      // writes to the register file
  logic [2:0]             ofs;
  spi_ctrl_u              ctrl_q;
  logic [DIVIDER_LEN-1:0] divider_q;
  logic [SS_NB-1:0]       ss_q;
  spi_word_t              div_merged;
  spi_word_t              ctrl_merged;
  spi_word_t              ss_merged;
  spi_word_t              rd_word;

  assign bus_valid = wb_cyc_i & wb_stb_i;
  assign ofs       = wb_adr_i[4:2];
  assign reg_wr    = bus_valid & wb_we_i & ~tip_i;

  // busy check for the data word lives in the shift register
  assign tx_load_o = bus_valid & wb_we_i & (ofs == SPI_ADR_DATA);

  assign div_merged  = byte_merge(32'(divider_q), wb_dat_i, wb_sel_i);
  assign ctrl_merged = byte_merge(32'(ctrl_q.raw), wb_dat_i, wb_sel_i);
  assign ss_merged   = byte_merge(32'(ss_q), wb_dat_i, wb_sel_i);

  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      divider_q <= '0;
    else if (reg_wr && (ofs == SPI_ADR_DIVIDER))
      divider_q <= div_merged[DIVIDER_LEN-1:0];
  end

  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      ctrl_q.raw <= '0;
    else if (reg_wr && (ofs == SPI_ADR_CTRL))
      ctrl_q.raw <= ctrl_merged[SPI_CTRL_BITS-1:0];
    else if (done_i)
      ctrl_q.f.go <= 1'b0; // transfer finished
  end

  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      ss_q <= '0;
    else if (reg_wr && (ofs == SPI_ADR_SS))
      ss_q <= ss_merged[SS_NB-1:0];
  end

  // active low pins, auto mode only selects during the transfer
  assign ss_pad_o = ~(ss_q & {SS_NB{~ctrl_q.f.ass | tip_i}});

  always_comb
  begin
    case (ofs)
      SPI_ADR_DATA:    rd_word = rx_data_i;
      SPI_ADR_CTRL:    rd_word = 32'(ctrl_q.raw);
      SPI_ADR_DIVIDER: rd_word = 32'(divider_q);
      SPI_ADR_SS:      rd_word = 32'(ss_q);
      default:         rd_word = '0; // unused offsets
    endcase
  end

  always_ff @(posedge wb_clk_i)
  begin
    wb_dat_o <= rd_word;
  end

  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      wb_ack_o <= 1'b0;
    else
      wb_ack_o <= bus_valid & ~wb_ack_o;
  end

  // level interrupt, set at the end of a transfer and dropped by any access
  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      wb_int_o <= 1'b0;
    else if (done_i && ctrl_q.f.ie)
      wb_int_o <= 1'b1;
    else if (wb_ack_o)
      wb_int_o <= 1'b0;
  end

  assign ctrl_o    = ctrl_q;
  assign divider_o = divider_q;

endmodule

`default_nettype wire

// File: logic/spi_xfer_fsm.sv
// go must stay high until done; the bit count is taken from char_len only while idle
`timescale 1ns/1ps
`default_nettype none

module spi_xfer_fsm (
  input  logic                                  wb_clk_i,
  input  logic                                  rst,
  input  logic                                  go_i,
  input  logic [spi_pkg::SPI_CHAR_LEN_BITS-1:0] char_len_i,
  input  logic                                  pos_edge_i,
  output logic                                  tip_o,
  output logic                                  done_o,
  output logic                                  last_o,
  output spi_pkg::spi_bit_cnt_t                 bit_cnt_o
);
  import spi_pkg::*;

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_XFER = 1'b1;

  logic         state_q;
  spi_bit_cnt_t cnt_q;    // bits still to clock
  spi_bit_cnt_t cnt_init;

  assign cnt_init  = (char_len_i == '0) ? spi_bit_cnt_t'(SPI_MAX_CHAR) : {1'b0, char_len_i};
  assign last_o    = (cnt_q == '0);
  assign tip_o     = (state_q == ST_XFER);
  assign done_o    = tip_o & last_o & pos_edge_i; // final rising edge
  assign bit_cnt_o = cnt_q;

  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      state_q <= ST_IDLE;
    else
    begin
      case (state_q)
        ST_IDLE: if (go_i) state_q <= ST_XFER;
        ST_XFER: if (done_o) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i or posedge rst)
  begin
    if (rst)
      cnt_q <= '0;
    else if (state_q == ST_IDLE)
      cnt_q <= cnt_init;
    else if (pos_edge_i && !last_o)
      cnt_q <= cnt_q - spi_bit_cnt_t'(1);
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the SPI master testbench with Verilator, runs it and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=spi_master_sim
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module spi_master_tb -Mdir "$OBJ_DIR" -o "$SIM_BIN" \
  -f spi_master_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// File: spi_master_top.f
logic/spi_pkg.sv
logic/spi_wb_regs.sv
logic/spi_clk_gen.sv
logic/spi_xfer_fsm.sv
logic/spi_shift_reg.sv
logic/spi_master_top.sv
tb/spi_master_properties.sv
tb/spi_master_tb.sv

// File: tb/spi_master_properties.sv
// bound into spi_master_top; uses its internal tip and ctrl signals and checks only after reset
`timescale 1ns/1ps
`default_nettype none

module spi_master_properties #(
  parameter int SS_NB = 8
) (
  input logic             wb_clk_i,
  input logic             rst,
  input logic             ack_i,
  input logic             int_i,
  input logic [SS_NB-1:0] ss_i,
  input logic             sclk_i,
  input logic             tip_i,
  input logic             ass_i,
  input logic             ie_i
);

  int unsigned fail_count = 0; // failed assertions so far

  ack_single: assert property (@(posedge wb_clk_i) disable iff (rst) ack_i |=> !ack_i)
    else
    begin
      fail_count = fail_count + 1;
      $error("wb_ack_o high on two cycles in a row");
    end

  // auto select keeps every slave off while idle
  ss_idle_off: assert property (@(posedge wb_clk_i) disable iff (rst)
    (ass_i && !tip_i) |-> (&ss_i))
    else
    begin
      fail_count = fail_count + 1;
      $error("ss_pad_o active outside a transfer in auto mode");
    end

  sclk_idle_low: assert property (@(posedge wb_clk_i) disable iff (rst) !tip_i |-> !sclk_i)
    else
    begin
      fail_count = fail_count + 1;
      $error("sclk_pad_o high outside a transfer");
    end

  int_needs_ie: assert property (@(posedge wb_clk_i) disable iff (rst)
    $rose(int_i) |-> $past(ie_i))
    else
    begin
      fail_count = fail_count + 1;
      $error("wb_int_o rose with the interrupt disabled");
    end

endmodule

bind spi_master_top spi_master_properties #(
  .SS_NB (SS_NB)
) u_props (
  .wb_clk_i (wb_clk_i),
  .rst      (rst),
  .ack_i    (wb_ack_o),
  .int_i    (wb_int_o),
  .ss_i     (ss_pad_o),
  .sclk_i   (sclk_pad_o),
  .tip_i    (tip),
  .ass_i    (ctrl.f.ass),
  .ie_i     (ctrl.f.ie)
);

`default_nettype wire

// File: tb/spi_master_tb.sv
// mosi is looped back to miso; runs with default parameters and a table with at most SS_NB = 8
`timescale 1ns/1ps
`default_nettype none

module spi_master_tb;
  import spi_pkg::*;

  localparam int DIVIDER_LEN = 16;
  localparam int SS_NB       = 8;
  localparam int NUM_FIXED   = 8;
  localparam int NUM_ROWS    = 12;
  localparam int MAX_DIV     = 5; // largest divider used by any row
  localparam int WD_CYCLES   = NUM_ROWS * 34 * 2 * (MAX_DIV + 1) + 1000;

  localparam logic [SS_NB-1:0] SS_IDLE = '1;

  typedef struct packed {
    spi_word_t               tx;
    logic [4:0]              char_len;
    logic                    lsb;
    logic [DIVIDER_LEN-1:0]  divider;
    logic [SS_NB-1:0]        ss;
    logic                    ass;
    logic                    ie;
    logic                    protect;  // divider write attempted mid transfer
  } xfer_row_t;

  logic             wb_clk_i = 1'b0;
  logic             rst;
  logic [4:0]       wb_adr_i;
  spi_word_t        wb_dat_i;
  logic [3:0]       wb_sel_i;
  logic             wb_we_i;
  logic             wb_stb_i;
  logic             wb_cyc_i;
  spi_word_t        wb_dat_o;
  logic             wb_ack_o;
  logic             wb_int_o;
  logic [SS_NB-1:0] ss_pad_o;
  logic             sclk_pad_o;
  logic             mosi_pad_o;

  xfer_row_t        rows [NUM_ROWS];
  int               seed = 71873;
  logic             mon_on = 1'b0;
  logic             sclk_prev = 1'b0;
  logic             int_seen = 1'b0;
  int               sclk_rises = 0;
  logic             cur_ass = 1'b0;
  logic [SS_NB-1:0] cur_ss = '0;

  spi_master_top #(
    .DIVIDER_LEN (DIVIDER_LEN),
    .SS_NB       (SS_NB)
  ) DUT (
    .wb_clk_i   (wb_clk_i),
    .rst        (rst),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_sel_i   (wb_sel_i),
    .wb_we_i    (wb_we_i),
    .wb_stb_i   (wb_stb_i),
    .wb_cyc_i   (wb_cyc_i),
    .miso_pad_i (mosi_pad_o), // loopback
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_int_o   (wb_int_o),
    .ss_pad_o   (ss_pad_o),
    .sclk_pad_o (sclk_pad_o),
    .mosi_pad_o (mosi_pad_o)
  );

  always
  begin
    #4 wb_clk_i = ~wb_clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input spi_word_t exp, input spi_word_t act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_ss(input string name, input logic [SS_NB-1:0] exp,
                          input logic [SS_NB-1:0] act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  // called 1 ns after a rising edge and returns 1 ns after the ack edge
  task automatic bus_cycle(input logic we, input logic [2:0] ofs, input spi_word_t wdat,
                           input logic [3:0] sel, output spi_word_t rdat);
    wb_adr_i = {ofs, 2'b00};
    wb_dat_i = wdat;
    wb_sel_i = sel;
    wb_we_i  = we;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    do
    begin
      @(posedge wb_clk_i);
      #1;
    end while (!wb_ack_o);
    rdat     = wb_dat_o;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] ofs, input spi_word_t wdat, input logic [3:0] sel);
    spi_word_t unused_rd;
    bus_cycle(1'b1, ofs, wdat, sel, unused_rd);
  endtask

  task automatic wb_read(input logic [2:0] ofs, output spi_word_t rdat);
    bus_cycle(1'b0, ofs, '0, 4'b1111, rdat);
  endtask

  task automatic fill_table();
    // tx word, char_len, lsb, divider, ss, ass, ie, busy write
    rows[0] = {32'hA5C3_0F1E, 5'd8,  1'b0, 16'd0, 8'h01, 1'b0, 1'b1, 1'b0};
    rows[1] = {32'h1234_5678, 5'd0,  1'b1, 16'd1, 8'h80, 1'b1, 1'b0, 1'b0};
    rows[2] = {32'hDEAD_BEEF, 5'd1,  1'b0, 16'd2, 8'h03, 1'b1, 1'b1, 1'b0};
    rows[3] = {32'h0000_ABCD, 5'd16, 1'b1, 16'd3, 8'h0F, 1'b0, 1'b0, 1'b1};
    rows[4] = {32'hCAFE_F00D, 5'd31, 1'b0, 16'd1, 8'h55, 1'b1, 1'b1, 1'b1};
    rows[5] = {32'h8000_0001, 5'd7,  1'b1, 16'd5, 8'hFF, 1'b0, 1'b1, 1'b0};
    rows[6] = {32'h7E81_3C96, 5'd24, 1'b0, 16'd0, 8'h20, 1'b1, 1'b0, 1'b0};
    rows[7] = {32'h0F0F_F0F0, 5'd13, 1'b1, 16'd4, 8'h00, 1'b1, 1'b1, 1'b1};
    for (int i = NUM_FIXED; i < NUM_ROWS; i++)
    begin
      rows[i]          = '0;
      rows[i].tx       = $random(seed);
      rows[i].char_len = 5'(i * 7); // spread of lengths
      rows[i].lsb      = i[0];
      rows[i].divider  = DIVIDER_LEN'(i % 3);
      rows[i].ss       = SS_NB'(1 << (i - NUM_FIXED));
      rows[i].ass      = i[1];
      rows[i].ie       = ~i[0];
    end
  endtask

  task automatic check_registers();
    spi_word_t rd;
    wb_write(SPI_ADR_DIVIDER, 32'h0000_1234, 4'b0011);
    wb_read(SPI_ADR_DIVIDER, rd);
    check_word("divider", 32'h0000_1234, rd);
    wb_write(SPI_ADR_DIVIDER, 32'hFFFF_AB99, 4'b0010); // byte 1 only
    wb_read(SPI_ADR_DIVIDER, rd);
    check_word("divider", 32'h0000_AB34, rd);
    wb_write(SPI_ADR_SS, 32'h0000_00A5, 4'b0001);
    wb_write(SPI_ADR_SS, 32'h0000_FF00, 4'b0010); // lane above the ss width
    wb_read(SPI_ADR_SS, rd);
    check_word("ss", 32'h0000_00A5, rd);
    check_ss("ss_pad_o", 8'h5A, ss_pad_o);
    wb_write(SPI_ADR_CTRL, 32'h0000_00E5, 4'b0001);
    wb_write(SPI_ADR_CTRL, 32'h0000_2A00, 4'b0010);
    wb_write(SPI_ADR_CTRL, 32'hFFFF_0000, 4'b1100);
    wb_read(SPI_ADR_CTRL, rd);
    check_word("ctrl", 32'h0000_2AE5, rd);
    check_ss("ss_pad_o", SS_IDLE, ss_pad_o); // auto select while idle
    for (int i = 1; i < 8; i++)
    begin
      if (i == 1 || i == 2 || i == 3 || i == 7)
      begin
        wb_write(3'(i), 32'hFFFF_FFFF, 4'b1111);
        wb_read(3'(i), rd);
        check_word("unused offset", 32'h0, rd);
      end
    end
    wb_read(SPI_ADR_DIVIDER, rd);
    check_word("divider", 32'h0000_AB34, rd);
    wb_read(SPI_ADR_CTRL, rd);
    check_word("ctrl", 32'h0000_2AE5, rd);
    wb_write(SPI_ADR_CTRL, 32'h0, 4'b1111);
  endtask

  task automatic run_row(input xfer_row_t r);
    spi_word_t              rd;
    spi_word_t              cfg;
    logic [DIVIDER_LEN-1:0] busy_div;
    int                     exp_rises;
    // mosi on the falling edge and miso on the rising edge
    cfg       = {18'd0, r.ass, r.ie, r.lsb, 1'b1, 1'b0, 1'b0, 3'b000, r.char_len};
    exp_rises = (r.char_len == 5'd0) ? 32 : int'(r.char_len);
    busy_div  = ~r.divider;
    wb_write(SPI_ADR_DIVIDER, 32'(r.divider), 4'b0011);
    wb_write(SPI_ADR_SS, 32'(r.ss), 4'b0001);
    wb_write(SPI_ADR_DATA, r.tx, 4'b1111);
    wb_write(SPI_ADR_CTRL, cfg, 4'b0011);
    wb_read(SPI_ADR_CTRL, rd);
    check_word("ctrl", cfg, rd);
    cur_ass = r.ass;
    cur_ss  = r.ss;
    check_ss("ss_pad_o before transfer", r.ass ? SS_IDLE : ~r.ss, ss_pad_o);
    sclk_rises = 0;
    int_seen   = 1'b0;
    mon_on     = 1'b1;
    wb_write(SPI_ADR_CTRL, cfg | 32'h0000_0100, 4'b0011); // set go
    if (r.protect)
    begin
      wb_read(SPI_ADR_CTRL, rd);
      check_bit("go during transfer", 1'b1, rd[8]);
      wb_write(SPI_ADR_DIVIDER, 32'(busy_div), 4'b0011);
    end
    do
    begin
      wb_read(SPI_ADR_CTRL, rd);
    end while (rd[8]);
    mon_on = 1'b0;
    check_word("sclk_pad_o rising edges", 32'(exp_rises), 32'(sclk_rises));
    check_bit("wb_int_o raised", r.ie, int_seen);
    check_ss("ss_pad_o after transfer", r.ass ? SS_IDLE : ~r.ss, ss_pad_o);
    wb_read(SPI_ADR_DATA, rd);
    check_word("rx data", r.tx, rd);
    @(posedge wb_clk_i);
    #1;
    check_bit("wb_int_o after ack", 1'b0, wb_int_o);
    if (r.protect)
    begin
      wb_read(SPI_ADR_DIVIDER, rd);
      check_word("divider after busy write", 32'(r.divider), rd);
    end
  endtask

  // pad monitor sampled mid cycle away from the stimulus
  always @(posedge wb_clk_i)
  begin
    #2;
    if (mon_on)
    begin
      if (sclk_pad_o && !sclk_prev)
        sclk_rises = sclk_rises + 1;
      if (wb_int_o)
        int_seen = 1'b1;
      if (sclk_pad_o || !cur_ass)
        check_ss("ss_pad_o during transfer", ~cur_ss, ss_pad_o);
    end
    sclk_prev = sclk_pad_o;
  end

  initial
  begin
    rst      = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_we_i  = 1'b0;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    fill_table();
    repeat (5) @(posedge wb_clk_i);
    #1;
    rst = 1'b0;
    check_bit("wb_ack_o", 1'b0, wb_ack_o);
    check_bit("wb_int_o", 1'b0, wb_int_o);
    check_bit("sclk_pad_o", 1'b0, sclk_pad_o);
    check_bit("mosi_pad_o", 1'b0, mosi_pad_o);
    check_ss("ss_pad_o", SS_IDLE, ss_pad_o);
    check_registers();
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(rows[i]);
    if (DUT.u_props.fail_count != 0)
      abort_run("a bound assertion on the bus or pad signals failed during the run");
    else
    begin
      $display(">>> PASS");
      $finish;
    end
  end

  // bound from the table size and the slowest divider
  initial
  begin
    repeat (WD_CYCLES) @(posedge wb_clk_i);
    abort_run("timeout: a transfer never finished in the time allowed for the table");
  end

endmodule

`default_nettype wire
